/* files.f */
icache_pkg.sv
icache_ifs.sv
line_sram.sv
tag_store.sv
lookup_stage.sv
select_stage.sv
icache_top.sv
icache_properties.sv
icache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module icache_tb -o icache_sim
./obj_dir/icache_sim 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

/* icache_tb.sv */
module icache_tb
	import icache_pkg::*;
();

	logic              clk;
	logic              rst;
	logic [addr_w-1:0] pc;
	logic              pc_valid;
	logic              flush;
	logic              id_ready;
	logic [line_w-1:0] mem_line;
	logic [inst_w-1:0] inst;
	logic              inst_valid;
	logic              mem_req;
	logic [addr_w-1:0] mem_addr;

	// Stimulus table, one row per test.
	string             t_name    [40];
	logic [addr_w-1:0] t_pc      [40];
	bit                t_valid   [40];
	bit                t_flush   [40];
	int                t_stall   [40];
	logic [inst_w-1:0] t_inst    [40];
	bit                t_req_chk [40]; // Clear where a repeat fetch may hit or refill.
	bit                t_req     [40];
	int                n_tests;
	int                n_pass;
	int                n_fail;

	icache_top u_icache_top (
		.clk        (clk),
		.rst        (rst),
		.pc         (pc),
		.pc_valid   (pc_valid),
		.flush      (flush),
		.id_ready   (id_ready),
		.mem_line   (mem_line),
		.inst       (inst),
		.inst_valid (inst_valid),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr)
	);

	always #4 clk = ~clk;

	// Backing memory. Every word is a fixed function of its byte address.
	function automatic logic [inst_w-1:0] model_word(input logic [addr_w-1:0] addr);
		return (addr[63:32] * 32'h9e37_79b9) ^ addr[31:0] ^ 32'h0bad_f00d;
	endfunction

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			mem_line[k*inst_w +: inst_w] = model_word(mem_addr + 64'(k * 4));
		end
	end

	// A req of 2 leaves mem_req unchecked.
	task automatic add_entry(input string name, input logic [addr_w-1:0] addr, input bit valid,
		input bit flush_req, input int stall, input int req);
		t_name[n_tests]    = name;
		t_pc[n_tests]      = addr;
		t_valid[n_tests]   = valid;
		t_flush[n_tests]   = flush_req;
		t_stall[n_tests]   = stall;
		t_inst[n_tests]    = model_word(addr);
		t_req_chk[n_tests] = (req != 2);
		t_req[n_tests]     = req[0];
		n_tests++;
	endtask

	task automatic record_result(input string name, input bit ok);
		if (ok) begin
			n_pass++;
			$display("test %s ok", name);
		end else begin
			n_fail++;
			$display("test %s failed", name);
		end
	endtask

	task automatic apply_entry(input int i);
		int          waited;
		bit          ok;
		logic [inst_w-1:0] held_inst;
		logic        held_valid;
		logic [addr_w-1:0] line_addr;
		ok        = 1'b1;
		line_addr = t_pc[i] & ~64'hf; // Line base of the fetch.
		@(negedge clk);
		pc       = t_pc[i];
		pc_valid = t_valid[i];
		flush    = t_flush[i];
		id_ready = 1'b1;
		#1;
		if (t_req_chk[i] && mem_req != t_req[i]) begin
			$display("ERR %s mem_req expected %0b actual %0b", t_name[i], t_req[i], mem_req);
			ok = 1'b0;
		end
		if (mem_addr != line_addr) begin
			$display("ERR %s mem_addr expected %h actual %h", t_name[i], line_addr, mem_addr);
			ok = 1'b0;
		end
		if (!t_valid[i] || t_flush[i]) begin
			// Nothing may come out of an idle or flushed cycle.
			@(negedge clk);
			pc_valid = 1'b0;
			flush    = 1'b0;
			if (inst_valid != 1'b0) begin
				$display("ERR %s inst_valid expected 0 actual %0b", t_name[i], inst_valid);
				ok = 1'b0;
			end
		end else begin
			waited = 0;
			do begin
				@(negedge clk);
				pc_valid = 1'b0;
				waited++;
			end while (inst_valid != 1'b1 && waited < 8);
			if (inst_valid != 1'b1) begin
				$display("%s timed out after %0d cycles waiting for inst_valid", t_name[i], waited);
				ok = 1'b0;
			end else begin
				if (waited != 1) begin
					$display("%s result came %0d edges after the request, not one", t_name[i],
						waited);
					ok = 1'b0;
				end
				if (inst != t_inst[i]) begin
					$display("ERR %s inst expected %h actual %h", t_name[i], t_inst[i], inst);
					ok = 1'b0;
				end
				if (u_icache_top.lk.addr_q != t_pc[i]) begin
					$display("ERR %s addr_q expected %h actual %h", t_name[i], t_pc[i],
						u_icache_top.lk.addr_q);
					ok = 1'b0;
				end
			end
			if (t_stall[i] > 0) begin
				held_inst  = inst;
				held_valid = inst_valid;
				id_ready   = 1'b0;
				repeat (t_stall[i]) begin
					@(negedge clk);
					if (inst != held_inst || inst_valid != held_valid) begin
						$display("%s output changed while id_ready was low", t_name[i]);
						ok = 1'b0;
					end
				end
				id_ready = 1'b1;
			end
		end
		record_result(t_name[i], ok);
	endtask

	initial begin
		logic [1:0] off;
		clk      = 1'b0;
		rst      = 1'b1;
		pc       = '0;
		pc_valid = 1'b0;
		flush    = 1'b0;
		id_ready = 1'b1;
		n_tests  = 0;
		n_pass   = 0;
		n_fail   = 0;
		void'($urandom(32'hc0c1_fa48));

		add_entry("cold_miss", 64'h0000_0000_0000_1230, 1, 0, 0, 1);
		add_entry("hit_word1", 64'h0000_0000_0000_1234, 1, 0, 0, 0);
		add_entry("hit_word2", 64'h0000_0000_0000_1238, 1, 0, 0, 0);
		add_entry("hit_word3", 64'h0000_0000_0000_123c, 1, 0, 0, 0);
		add_entry("hit_word0", 64'h0000_0000_0000_1230, 1, 0, 0, 0);
		// Five tags on set 5, one more than the ways.
		add_entry("evict_a", 64'h0000_0000_0000_0454, 1, 0, 0, 1);
		add_entry("evict_b", 64'h0000_0000_0000_0858, 1, 0, 0, 1);
		add_entry("evict_c", 64'h0000_0000_0000_0c5c, 1, 0, 0, 1);
		add_entry("evict_d", 64'h8000_0000_0000_0050, 1, 0, 0, 1);
		add_entry("evict_e", 64'h0123_4567_89ab_c050, 1, 0, 0, 1);
		add_entry("repeat_e", 64'h0123_4567_89ab_c054, 1, 0, 0, 0);
		add_entry("repeat_a", 64'h0000_0000_0000_0450, 1, 0, 0, 2);
		add_entry("repeat_b", 64'h0000_0000_0000_085c, 1, 0, 0, 2);
		add_entry("repeat_c", 64'h0000_0000_0000_0c54, 1, 0, 0, 2);
		add_entry("repeat_d", 64'h8000_0000_0000_0058, 1, 0, 0, 2);
		add_entry("flush_drop", 64'h0000_0000_0000_1234, 1, 1, 0, 0);
		add_entry("after_flush", 64'h0000_0000_0000_1238, 1, 0, 0, 0);
		add_entry("stall_hit", 64'h0000_0000_0000_123c, 1, 0, 5, 0);
		add_entry("after_stall", 64'h0000_0000_0000_1230, 1, 0, 0, 0);
		add_entry("stall_miss", 64'h0000_0000_0001_0a00, 1, 0, 3, 1);
		add_entry("after_stall_miss", 64'h0000_0000_0001_0a08, 1, 0, 0, 0);
		add_entry("idle", 64'h0000_0000_0000_0000, 0, 0, 0, 0);
		add_entry("hit_after_idle", 64'h0000_0000_0001_0a0c, 1, 0, 0, 0);
		for (int f = 0; f < 4; f++) begin
			off = 2'($urandom);
			add_entry($sformatf("filler_%0d", f), {60'h123, off, 2'b00}, 1, 0, 0, 0);
		end

		repeat (10) @(negedge clk);
		rst = 1'b0;
		if (inst_valid != 1'b0 || mem_req != 1'b0) begin
			$display("inst_valid or mem_req high right after reset");
			record_result("reset", 1'b0);
		end else begin
			record_result("reset", 1'b1);
		end

		for (int i = 0; i < n_tests; i++) begin
			apply_entry(i);
		end

		$display("tests %0d passed %0d failed %0d", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// Hard limit on the run.
	initial begin
		#20000;
		$display("simulation time limit reached before the test sequence ended");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* icache_properties.sv */
module icache_properties
	import icache_pkg::*;
(
	input logic              clk,
	input logic              rst,
	input logic              pc_valid,
	input logic              flush,
	input logic              id_ready,
	input logic [inst_w-1:0] inst,
	input logic              inst_valid,
	input logic              mem_req
);

	// A flushed request never produces a result.
	flush_drops_result: assert property (@(posedge clk) disable iff (rst)
		flush && id_ready |=> !inst_valid)
		else $error("inst_valid high in the cycle after a flush");

	stall_holds_output: assert property (@(posedge clk) disable iff (rst)
		!id_ready |=> $stable(inst) && $stable(inst_valid))
		else $error("instruction output moved while id_ready was low");

	no_req_when_idle: assert property (@(posedge clk) disable iff (rst)
		!pc_valid |-> !mem_req)
		else $error("mem_req high with pc_valid low");

endmodule

bind icache_top icache_properties u_icache_properties (
	.clk        (clk),
	.rst        (rst),
	.pc_valid   (pc_valid),
	.flush      (flush),
	.id_ready   (id_ready),
	.inst       (inst),
	.inst_valid (inst_valid),
	.mem_req    (mem_req)
);

/* icache_top.sv */
module icache_top
	import icache_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [addr_w-1:0] pc,
	input  logic              pc_valid,
	input  logic              flush,
	input  logic              id_ready,
	input  logic [line_w-1:0] mem_line,
	output logic [inst_w-1:0] inst,
	output logic              inst_valid,
	output logic              mem_req,
	output logic [addr_w-1:0] mem_addr
);

	logic [ways-1:0] way_hit;
	logic [ways-1:0] wr_way;

	lookup_if lk ();
	sram_if   sif [ways] ();

	assign mem_addr = {pc[addr_w-1:offset_w], {offset_w{1'b0}}}; // Line aligned.

	tag_store u_tag_store (
		.clk      (clk),
		.rst      (rst),
		.rd_index (pc[index_lsb +: index_w]),
		.rd_tag   (pc[tag_lsb +: tag_w]),
		.wr_way   (wr_way),
		.wr_index (pc[index_lsb +: index_w]),
		.wr_tag   (pc[tag_lsb +: tag_w]),
		.way_hit  (way_hit)
	);

	lookup_stage u_lookup_stage (
		.clk      (clk),
		.rst      (rst),
		.pc       (pc),
		.pc_valid (pc_valid),
		.flush    (flush),
		.id_ready (id_ready),
		.mem_line (mem_line),
		.way_hit  (way_hit),
		.mem_req  (mem_req),
		.wr_way   (wr_way),
		.s        (lk.src),
		.sram0    (sif[0].ctrl),
		.sram1    (sif[1].ctrl),
		.sram2    (sif[2].ctrl),
		.sram3    (sif[3].ctrl)
	);

	for (genvar w = 0; w < ways; w++) begin : g_sram
		line_sram u_line_sram (
			.clk (clk),
			.m   (sif[w].mem)
		);
	end

	select_stage u_select_stage (
		.clk        (clk),
		.rst        (rst),
		.d          (lk.dst),
		.dout0      (sif[0].dout),
		.dout1      (sif[1].dout),
		.dout2      (sif[2].dout),
		.dout3      (sif[3].dout),
		.inst       (inst),
		.inst_valid (inst_valid)
	);

endmodule

/* select_stage.sv */
// Second pipeline stage.
module select_stage
	import icache_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	lookup_if.dst             d,
	input  logic [line_w-1:0] dout0,
	input  logic [line_w-1:0] dout1,
	input  logic [line_w-1:0] dout2,
	input  logic [line_w-1:0] dout3,
	output logic [inst_w-1:0] inst,
	output logic              inst_valid
);

	logic [line_w-1:0] dout_w [ways];
	logic [line_w-1:0] line;
	logic [inst_w-1:0] word;
	logic [inst_w-1:0] last_q;

	assign dout_w[0] = dout0;
	assign dout_w[1] = dout1;
	assign dout_w[2] = dout2;
	assign dout_w[3] = dout3;

	// Refill line unless a way hit.
	always_comb begin
		line = d.refill_q;
		for (int w = 0; w < ways; w++) begin
			if (d.way_hit_q[w]) begin
				line = dout_w[w];
			end
		end
	end

	assign word = line[d.word_q * inst_w +: inst_w];

	// Keep the last delivered word on the bus while nothing is pending.
	always_ff @(posedge clk) begin
		if (rst) begin
			last_q <= '0;
		end else if (d.pend) begin
			last_q <= word;
		end
	end

	assign inst       = d.pend ? word : last_q;
	assign inst_valid = d.pend;

endmodule

/* lookup_stage.sv */
// First pipeline stage.
module lookup_stage
	import icache_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [addr_w-1:0] pc,
	input  logic              pc_valid,
	input  logic              flush,
	input  logic              id_ready,
	input  logic [line_w-1:0] mem_line,
	input  logic [ways-1:0]   way_hit,
	output logic              mem_req,
	output logic [ways-1:0]   wr_way,
	lookup_if.src             s,
	sram_if.ctrl              sram0,
	sram_if.ctrl              sram1,
	sram_if.ctrl              sram2,
	sram_if.ctrl              sram3
);

	logic               take;
	logic               miss;
	logic [ways-1:0]    en_way;
	logic [ways-1:0]    repl_q; // One-hot victim pointer.
	logic [index_w-1:0] index;

	assign index = pc[index_lsb +: index_w];
	assign take  = pc_valid && id_ready;
	assign miss  = take && (way_hit == '0);

	// Hit way, or the victim on a miss.
	always_comb begin
		en_way = '0;
		if (take) begin
			en_way = (way_hit != '0) ? way_hit : repl_q;
		end
	end

	assign mem_req = miss;
	assign wr_way  = miss ? en_way : '0;

	assign sram0.cen  = ~en_way[0];
	assign sram0.wen  = ~miss;
	assign sram0.addr = index;
	assign sram0.din  = mem_line;

	assign sram1.cen  = ~en_way[1];
	assign sram1.wen  = ~miss;
	assign sram1.addr = index;
	assign sram1.din  = mem_line;

	assign sram2.cen  = ~en_way[2];
	assign sram2.wen  = ~miss;
	assign sram2.addr = index;
	assign sram2.din  = mem_line;

	assign sram3.cen  = ~en_way[3];
	assign sram3.wen  = ~miss;
	assign sram3.addr = index;
	assign sram3.din  = mem_line;

	always_ff @(posedge clk) begin
		if (rst) begin
			s.pend      <= 1'b0;
			s.way_hit_q <= '0;
			repl_q      <= {{(ways - 1){1'b0}}, 1'b1};
		end else if (id_ready) begin
			if (flush) begin
				s.pend      <= 1'b0; // Drop the request in flight.
				s.way_hit_q <= '0;
			end else begin
				s.pend      <= pc_valid;
				s.way_hit_q <= way_hit;
				repl_q      <= {repl_q[ways-2:0], repl_q[ways-1]};
			end
		end
	end

	// Payload follows the request, held during a stall.
	always_ff @(posedge clk) begin
		if (id_ready) begin
			s.word_q   <= pc[word_lsb +: word_w];
			s.refill_q <= mem_line;
			s.addr_q   <= pc;
		end
	end

endmodule

/* tag_store.sv */
module tag_store
	import icache_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [index_w-1:0] rd_index,
	input  logic [tag_w-1:0]   rd_tag,
	input  logic [ways-1:0]    wr_way,
	input  logic [index_w-1:0] wr_index,
	input  logic [tag_w-1:0]   wr_tag,
	output logic [ways-1:0]    way_hit
);

	logic [tag_w-1:0] tag_mem [ways][sets];
	logic [sets-1:0]  valid_q [ways];

	for (genvar w = 0; w < ways; w++) begin : g_way

		always_ff @(posedge clk) begin
			if (rst) begin
				valid_q[w] <= '0;
			end else if (wr_way[w]) begin
				valid_q[w][wr_index] <= 1'b1;
			end
		end

		always_ff @(posedge clk) begin
			if (wr_way[w]) begin
				tag_mem[w][wr_index] <= wr_tag;
			end
		end

		// Combinational compare against the current fetch.
		assign way_hit[w] = valid_q[w][rd_index] && (tag_mem[w][rd_index] == rd_tag);

	end

endmodule

/* line_sram.sv */
// Behavioural single-port line SRAM.
module line_sram
	import icache_pkg::*;
(
	input logic clk,
	sram_if.mem m
);

	logic [line_w-1:0] mem [sets];

	// Output register only moves on an enabled cycle.
	always_ff @(posedge clk) begin
		if (!m.cen) begin
			if (!m.wen) begin
				mem[m.addr] <= m.din;
				m.dout      <= m.din; // Write-through.
			end else begin
				m.dout <= mem[m.addr];
			end
		end
	end

endmodule

/* icache_ifs.sv */
// Registered bundle from the lookup stage to the select stage.
interface lookup_if
	import icache_pkg::*;
();
	logic                pend;      // A result is in flight.
	logic [ways-1:0]     way_hit_q; // One-hot, zero on a miss.
	logic [word_w-1:0]   word_q;
	logic [line_w-1:0]   refill_q;  // Line fetched from memory on a miss.
	logic [addr_w-1:0]   addr_q;

	modport src (
		output pend,
		output way_hit_q,
		output word_q,
		output refill_q,
		output addr_q
	);

	modport dst (
		input pend,
		input way_hit_q,
		input word_q,
		input refill_q,
		input addr_q
	);
endinterface

// One line SRAM, control from the lookup stage.
interface sram_if
	import icache_pkg::*;
();
	logic               cen;  // Active low.
	logic               wen;  // Active low.
	logic [index_w-1:0] addr;
	logic [line_w-1:0]  din;
	logic [line_w-1:0]  dout;

	modport ctrl (output cen, output wen, output addr, output din);
	modport mem  (input cen, input wen, input addr, input din, output dout);
endinterface

/* icache_pkg.sv */
package icache_pkg;

	// Cache geometry.
	localparam int addr_w = 64;
	localparam int line_w = 128;
	localparam int inst_w = 32;
	localparam int ways   = 4;
	localparam int sets   = 64;

	// Address fields, derived from the geometry.
	localparam int offset_w = $clog2(line_w / 8);     // Byte within a line.
	localparam int index_w  = $clog2(sets);           // Set select.
	localparam int tag_w    = addr_w - index_w - offset_w;
	localparam int word_w   = $clog2(line_w / inst_w); // Instruction within a line.

	// Field positions inside a fetch address.
	localparam int word_lsb  = $clog2(inst_w / 8);    // Instructions are word aligned.
	localparam int index_lsb = offset_w;
	localparam int tag_lsb   = offset_w + index_w;

endpackage
